/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run tb_apu_regs and check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_apu_regs -f tb.f
	-obj_dir/Vtb_apu_regs > sim.log 2>&1
	@cat sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb.f */
verilog/apu_pkg.sv
verilog/apu_decode.sv
verilog/apu_regfile.sv
verilog/apu_power.sv
verilog/apu_wave_ram.sv
verilog/apu_read_mux.sv
verilog/apu_regs_top.sv
verification/tb_apu_regs.sv

/* verification/apu_vectors.txt */
# op addr data expect, all hex. W write, R read with expect the rdata value, C strobe check.
# for C, data[1:0] is {cpu_wr, cpu_rd} and expect[2:0] is {nr30 bit 7, ff00wr, ff00rd}.
W FF12 F3 00
W FF1A 80 00
W FF24 77 00
R FF10 00 80
R FF11 00 3F
R FF12 00 00
R FF13 00 FF
R FF14 00 BF
R FF15 00 FF
R FF16 00 3F
R FF17 00 00
R FF18 00 FF
R FF19 00 BF
R FF1A 00 7F
R FF1B 00 FF
R FF1C 00 9F
R FF1D 00 FF
R FF1E 00 BF
R FF1F 00 FF
R FF20 00 FF
R FF21 00 00
R FF22 00 00
R FF23 00 BF
R FF24 00 00
R FF25 00 00
R FF26 00 70
C FF00 02 00
C FF00 01 03
W FF30 01 00
W FF31 23 00
W FF32 45 00
W FF33 67 00
W FF34 89 00
W FF35 AB 00
W FF36 CD 00
W FF37 EF 00
# power on
W FF26 80 00
R FF26 00 F0
W FF12 F3 00
W FF1A 80 00
W FF24 77 00
W FF1C 20 00
W FF15 12 00
R FF12 00 F3
R FF1A 00 FF
R FF24 00 77
R FF1C 00 BF
R FF15 00 FF
R FF1F 00 FF
R FF27 00 FF
R FF2F 00 FF
R FF26 00 F0
C FF00 02 04
C FF00 01 07
C FF26 01 06
W FF38 10 00
W FF39 32 00
W FF3A 54 00
W FF3B 76 00
W FF3C 98 00
W FF3D BA 00
W FF3E DC 00
W FF3F FE 00
# wave dac off, then the strobes and addresses outside the ff page
W FF1A 00 00
R FF1A 00 7F
C FF00 01 03
C FF00 02 00
C 7F00 02 02
C FE00 01 02
R 7F26 00 FF
R 1F10 00 FF
R FE30 00 FF
R FF26 00 F0
# power off, registers read bare masks from the second cycle on
W FF26 00 00
R FF26 00 70
R FF12 00 00
R FF1A 00 7F
R FF24 00 00
R FF1C 00 9F
W FF12 F3 00
R FF12 00 00
C FF00 01 03
R FF30 00 01
R FF31 00 23
R FF32 00 45
R FF33 00 67
R FF34 00 89
R FF35 00 AB
R FF36 00 CD
R FF37 00 EF
R FF38 00 10
R FF39 00 32
R FF3A 00 54
R FF3B 00 76
R FF3C 00 98
R FF3D 00 BA
R FF3E 00 DC
R FF3F 00 FE

/* verification/tb_apu_regs.sv */
`timescale 1ns/10ps

module tb_apu_regs import apu_pkg::*; ();

	localparam int    CLK_PERIOD    = 100;  // ns.
	localparam int    RESET_CYCLES  = 10;
	localparam int    RESET_TIMEOUT = 40;   // cycles.
	localparam int    OPEN_RETRIES  = 4;
	localparam int    MAX_LINES     = 1000;
	localparam string VEC_FILE      = "verification/apu_vectors.txt";

	logic     clk;
	logic     rst_n;
	addr_t    a;
	data_t    wdata;
	logic     cpu_wr;
	logic     cpu_rd;
	ch_mask_t ch_on;
	logic     nch1_amp_en;
	logic     nch2_amp_en;
	logic     nch4_amp_en;
	data_t    rdata;
	logic     ff00wr;
	logic     ff00rd;
	logic     namp_en;

	int fd;
	int n_checks;

	apu_regs_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.a           (a),
		.wdata       (wdata),
		.cpu_wr      (cpu_wr),
		.cpu_rd      (cpu_rd),
		.ch_on       (ch_on),
		.nch1_amp_en (nch1_amp_en),
		.nch2_amp_en (nch2_amp_en),
		.nch4_amp_en (nch4_amp_en),
		.rdata       (rdata),
		.ff00wr      (ff00wr),
		.ff00rd      (ff00rd),
		.namp_en     (namp_en)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end else begin
			n_checks++;
		end
	endtask

	task automatic check_strobe(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
			abort_run();
		end else begin
			n_checks++;
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			if (cycles == RESET_TIMEOUT) begin
				$display("Error: reset still active after %0d cycles", RESET_TIMEOUT);
				abort_run();
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	task automatic open_vectors();
		int tries;
		tries = 0;
		fd = $fopen(VEC_FILE, "r");
		while (fd == 0) begin
			if (tries == OPEN_RETRIES) begin
				$display("Error: cannot open the vector file %s", VEC_FILE);
				abort_run();
			end else begin
				@(posedge clk);
				tries++;
				fd = $fopen(VEC_FILE, "r");
			end
		end
	endtask

	// one bus operation per clock, driven on the falling edge.
	task automatic apply_op(input logic [7:0] op, input addr_t addr, input data_t data,
			input data_t expected);
		data_t exp_rd;
		logic  exp_namp;
		@(negedge clk);
		a           = addr;
		wdata       = data;
		cpu_wr      = (op == "W") || (op == "C" && data[1]);
		cpu_rd      = (op == "R") || (op == "C" && data[0]);
		ch_on       = ch_mask_t'($urandom);
		nch1_amp_en = ($urandom % 4) != 0;  // mostly high.
		nch2_amp_en = ($urandom % 4) != 0;
		nch4_amp_en = ($urandom % 4) != 0;
		#(CLK_PERIOD / 2 - 10);  // just before the rising edge.
		case (op)
			"W": ;
			"R": begin
				exp_rd = expected;
				if (addr == 16'hFF26 && expected[7])
					exp_rd = expected | {4'b0, ch_on};  // channel flags while powered.
				check_data("rdata", exp_rd, rdata);
			end
			"C": begin
				exp_namp = !expected[2] && nch1_amp_en && nch2_amp_en && nch4_amp_en;
				check_strobe("ff00wr", expected[1], ff00wr);
				check_strobe("ff00rd", expected[0], ff00rd);
				check_strobe("namp_en", exp_namp, namp_en);
			end
			default: begin
				$display("Error: unknown operation %c in the vector file", op);
				abort_run();
			end
		endcase
	endtask

	task automatic run_vectors();
		string      line;
		int         n_chars;
		int         n_lines;
		logic [7:0] op;
		addr_t      addr;
		data_t      data;
		data_t      expected;
		n_lines = 0;
		while (!$feof(fd)) begin
			if (n_lines == MAX_LINES) begin
				$display("Error: vector file is longer than %0d lines", MAX_LINES);
				abort_run();
			end else begin
				n_lines++;
				n_chars = $fgets(line, fd);
				if (n_chars > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%c %h %h %h", op, addr, data, expected) != 4) begin
						$display("Error: malformed vector on line %0d", n_lines);
						abort_run();
					end else begin
						apply_op(op, addr, data, expected);
					end
				end
			end
		end
		$fclose(fd);
	endtask

	initial begin
		void'($urandom(32'h3c7c_db9c));
		a           = '0;
		wdata       = '0;
		cpu_wr      = 1'b0;
		cpu_rd      = 1'b0;
		ch_on       = '0;
		nch1_amp_en = 1'b1;
		nch2_amp_en = 1'b1;
		nch4_amp_en = 1'b1;
		n_checks    = 0;
		wait_reset_release();
		@(negedge clk);
		#(CLK_PERIOD / 2 - 10);
		check_data("rdata", 8'hFF, rdata);  // idle bus reads ones.
		open_vectors();
		run_vectors();
		@(posedge clk);
		if (n_checks < 2) begin
			$display("Error: no checks were taken from %s", VEC_FILE);
			abort_run();
		end else begin
			$display("%0d checks done", n_checks);
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

/* verilog/apu_decode.sv */
`timescale 1ns/10ps

module apu_decode import apu_pkg::*; (
	input  addr_t     a,
	input  logic      cpu_wr,
	input  logic      cpu_rd,
	input  logic      nr30_dac,
	input  logic      nch1_amp_en,
	input  logic      nch2_amp_en,
	input  logic      nch4_amp_en,
	output logic      ff00wr,
	output logic      ff00rd,
	output logic      reg_sel,
	output reg_idx_t  reg_idx,
	output logic      ff26_sel,
	output logic      wave_sel,
	output wave_idx_t wave_idx,
	output logic      namp_en
);

	logic ffxx;
	logic ff00;
	logic ff1x, ff2x, ff3x;
	logic [15:0] nib;
	logic [REG_COUNT-1:0] sel;

	assign ffxx = &a[15:8];  // ff page.

	// joypad strobes.
	assign ff00   = ffxx && (a[7:0] == 8'h00);
	assign ff00wr = !(ff00 && cpu_wr);
	assign ff00rd = ff00 && cpu_rd;

	// sub-pages.
	assign ff1x = ffxx && !a[7] && !a[6] && !a[5] && a[4];
	assign ff2x = ffxx && !a[7] && !a[6] && a[5] && !a[4];
	assign ff3x = ffxx && !a[7] && !a[6] && a[5] && a[4];

	// one four-input term per low nibble value.
	for (genvar i = 0; i < 16; i++) begin : g_nib
		assign nib[i] = (a[3:0] == 4'(i));
	end

	assign sel[0]  = ff1x && nib[0];   // nr10.
	assign sel[1]  = ff1x && nib[1];
	assign sel[2]  = ff1x && nib[2];
	assign sel[3]  = ff1x && nib[3];
	assign sel[4]  = ff1x && nib[4];
	assign sel[5]  = 1'b0;             // ff15 has no register.
	assign sel[6]  = ff1x && nib[6];   // nr21.
	assign sel[7]  = ff1x && nib[7];
	assign sel[8]  = ff1x && nib[8];
	assign sel[9]  = ff1x && nib[9];
	assign sel[10] = ff1x && nib[10];  // nr30.
	assign sel[11] = ff1x && nib[11];
	assign sel[12] = ff1x && nib[12];
	assign sel[13] = ff1x && nib[13];
	assign sel[14] = ff1x && nib[14];
	assign sel[15] = 1'b0;             // ff1f has no register.
	assign sel[16] = ff2x && nib[0];   // nr41.
	assign sel[17] = ff2x && nib[1];
	assign sel[18] = ff2x && nib[2];
	assign sel[19] = ff2x && nib[3];
	assign sel[20] = ff2x && nib[4];   // nr50.
	assign sel[21] = ff2x && nib[5];   // nr51.

	assign ff26_sel = ff2x && nib[6];

	assign wave_sel = ff3x;
	assign wave_idx = a[3:0];

	assign reg_sel = |sel;

	// selects are one-hot, so a plain scan encodes them.
	always_comb begin
		reg_idx = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			if (sel[i])
				reg_idx = reg_idx_t'(i);
		end
	end

	// amplifiers off only with the wave dac off and all enables inactive.
	assign namp_en = !nr30_dac && nch1_amp_en && nch2_amp_en && nch4_amp_en;

	// register, nr52 and wave ram pages never overlap.
	always_comb begin
		assert ($onehot0({reg_sel, ff26_sel, wave_sel}))
			else $error("apu_decode: more than one register block selected");
	end

endmodule

/* verilog/apu_pkg.sv */
package apu_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [4:0]  reg_idx_t;  // low byte minus 0x10.
	typedef logic [3:0]  wave_idx_t;
	typedef logic [3:0]  ch_mask_t;

	typedef enum logic {
		PWR_OFF = 1'b0,
		PWR_ON  = 1'b1
	} power_state_t;

	// ff10 up to ff25.
	localparam int REG_COUNT = 22;

	localparam reg_idx_t NR30_IDX = 5'd10;

	// bits set here always read back as one.
	localparam data_t reg_read_mask [0:REG_COUNT-1] = '{
		8'h80, 8'h3F, 8'h00, 8'hFF, 8'hBF,  // nr10 to nr14.
		8'hFF,                              // ff15 unused.
		8'h3F, 8'h00, 8'hFF, 8'hBF,         // nr21 to nr24.
		8'h7F, 8'hFF, 8'h9F, 8'hFF, 8'hBF,  // nr30 to nr34.
		8'hFF,                              // ff1f unused.
		8'hFF, 8'h00, 8'h00, 8'hBF,         // nr41 to nr44.
		8'h00, 8'h00                        // nr50, nr51.
	};

	localparam data_t nr52_read_mask = 8'h70;

endpackage

/* verilog/apu_power.sv */
`timescale 1ns/10ps

module apu_power import apu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     cpu_wr,
	input  logic     ff26_sel,
	input  data_t    wdata,
	input  ch_mask_t ch_on,
	output logic     regs_clear,
	output data_t    nr52_rdata
);

	power_state_t state;
	power_state_t state_nxt;
	logic         pwr_on;
	ch_mask_t     ch_status;

	// only bit 7 of nr52 is writable.
	always_comb begin
		state_nxt = state;
		if (cpu_wr && ff26_sel) begin
			case (state)
				PWR_OFF: if (wdata[7])  state_nxt = PWR_ON;
				PWR_ON:  if (!wdata[7]) state_nxt = PWR_OFF;
				default: state_nxt = PWR_OFF;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= PWR_OFF;
		else
			state <= state_nxt;
	end

	assign pwr_on     = (state == PWR_ON);
	assign regs_clear = !pwr_on;

	// channel flags read zero while off.
	assign ch_status = ch_on & {4{pwr_on}};

	assign nr52_rdata = {pwr_on, 7'b0} | nr52_read_mask | {4'b0, ch_status};

endmodule

/* verilog/apu_read_mux.sv */
`timescale 1ns/10ps

module apu_read_mux import apu_pkg::*; (
	input  logic  cpu_rd,
	input  logic  reg_sel,
	input  logic  ff26_sel,
	input  logic  wave_sel,
	input  data_t reg_rdata,
	input  data_t nr52_rdata,
	input  data_t wave_rdata,
	output data_t rdata
);

	always_comb begin
		rdata = 8'hFF;  // open bus.
		if (cpu_rd) begin
			if (reg_sel)
				rdata = reg_rdata;
			else if (ff26_sel)
				rdata = nr52_rdata;
			else if (wave_sel)
				rdata = wave_rdata;
		end
	end

	// a selected source must be fully initialised by reset.
	always_comb begin
		if (cpu_rd)
			assert (!$isunknown(rdata))
				else $error("apu_read_mux: unknown read data");
	end

endmodule

/* verilog/apu_regfile.sv */
`timescale 1ns/10ps

module apu_regfile import apu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     cpu_wr,
	input  logic     reg_sel,
	input  reg_idx_t reg_idx,
	input  data_t    wdata,
	input  logic     regs_clear,
	output data_t    reg_rdata,
	output logic     nr30_dac
);

	data_t regs [0:REG_COUNT-1];
	logic  reg_we;
	logic  any_set;

	// sound registers are locked while power is off.
	assign reg_we = cpu_wr && reg_sel && !regs_clear;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (regs_clear) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (reg_we) begin
			regs[reg_idx] <= wdata;
		end
	end

	// masked readback.
	always_comb begin
		if (reg_idx < reg_idx_t'(REG_COUNT))
			reg_rdata = regs[reg_idx] | reg_read_mask[reg_idx];
		else
			reg_rdata = 8'hFF;  // past ff25.
	end

	assign nr30_dac = regs[NR30_IDX][7];

	always_comb begin
		any_set = 1'b0;
		for (int i = 0; i < REG_COUNT; i++)
			any_set = any_set || (regs[i] != '0);
	end

	// one cycle into power-off every register is zero and stays there.
	a_clear_holds: assert property (
		@(posedge clk) disable iff (!rst_n)
		regs_clear |=> !any_set
	) else $error("apu_regfile: register nonzero while power is off");

endmodule

/* verilog/apu_regs_top.sv */
`timescale 1ns/10ps

module apu_regs_top import apu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  addr_t    a,
	input  data_t    wdata,
	input  logic     cpu_wr,
	input  logic     cpu_rd,
	input  ch_mask_t ch_on,
	input  logic     nch1_amp_en,
	input  logic     nch2_amp_en,
	input  logic     nch4_amp_en,
	output data_t    rdata,
	output logic     ff00wr,
	output logic     ff00rd,
	output logic     namp_en
);

	logic      reg_sel;
	reg_idx_t  reg_idx;
	logic      ff26_sel;
	logic      wave_sel;
	wave_idx_t wave_idx;
	logic      regs_clear;
	logic      nr30_dac;
	data_t     reg_rdata;
	data_t     nr52_rdata;
	data_t     wave_rdata;

	apu_decode u_decode (
		.a           (a),
		.cpu_wr      (cpu_wr),
		.cpu_rd      (cpu_rd),
		.nr30_dac    (nr30_dac),
		.nch1_amp_en (nch1_amp_en),
		.nch2_amp_en (nch2_amp_en),
		.nch4_amp_en (nch4_amp_en),
		.ff00wr      (ff00wr),
		.ff00rd      (ff00rd),
		.reg_sel     (reg_sel),
		.reg_idx     (reg_idx),
		.ff26_sel    (ff26_sel),
		.wave_sel    (wave_sel),
		.wave_idx    (wave_idx),
		.namp_en     (namp_en)
	);

	apu_regfile u_regfile (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_wr     (cpu_wr),
		.reg_sel    (reg_sel),
		.reg_idx    (reg_idx),
		.wdata      (wdata),
		.regs_clear (regs_clear),
		.reg_rdata  (reg_rdata),
		.nr30_dac   (nr30_dac)
	);

	apu_power u_power (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_wr     (cpu_wr),
		.ff26_sel   (ff26_sel),
		.wdata      (wdata),
		.ch_on      (ch_on),
		.regs_clear (regs_clear),
		.nr52_rdata (nr52_rdata)
	);

	apu_wave_ram u_wave_ram (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_wr     (cpu_wr),
		.wave_sel   (wave_sel),
		.wave_idx   (wave_idx),
		.wdata      (wdata),
		.wave_rdata (wave_rdata)
	);

	apu_read_mux u_read_mux (
		.cpu_rd     (cpu_rd),
		.reg_sel    (reg_sel),
		.ff26_sel   (ff26_sel),
		.wave_sel   (wave_sel),
		.reg_rdata  (reg_rdata),
		.nr52_rdata (nr52_rdata),
		.wave_rdata (wave_rdata),
		.rdata      (rdata)
	);

endmodule

/* verilog/apu_wave_ram.sv */
`timescale 1ns/10ps

module apu_wave_ram import apu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cpu_wr,
	input  logic      wave_sel,
	input  wave_idx_t wave_idx,
	input  data_t     wdata,
	output data_t     wave_rdata
);

	localparam int WAVE_BYTES = 16;

	data_t mem [0:WAVE_BYTES-1];

	// writable whatever the power state.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < WAVE_BYTES; i++)
				mem[i] <= '0;
		end else if (cpu_wr && wave_sel) begin
			mem[wave_idx] <= wdata;
		end
	end

	assign wave_rdata = mem[wave_idx];  // async read.

endmodule
